// File: filelist.f
src/mips_isa_pkg.sv
src/alu_ctrl_pkg.sv
src/alu_decoder.sv
src/decode_stage.sv
src/pipe_stage_reg.sv
src/alu_execute.sv
src/exec_pipe_top.sv
verification/exec_pipe_checker.sv
verification/exec_pipe_tb.sv

// File: verification/exec_pipe_tb.sv
`timescale 1ns/1ns

module exec_pipe_tb;

	localparam int WAIT_LIMIT = 100;
	// kept R-type functs, I-type opcodes and REGIMM rt codes
	localparam logic [6*22-1:0] R_FUNCTS = {
		mips_isa_pkg::EXE_AND, mips_isa_pkg::EXE_OR, mips_isa_pkg::EXE_XOR,
		mips_isa_pkg::EXE_NOR, mips_isa_pkg::EXE_ADD, mips_isa_pkg::EXE_ADDU,
		mips_isa_pkg::EXE_SUB, mips_isa_pkg::EXE_SUBU, mips_isa_pkg::EXE_SLT,
		mips_isa_pkg::EXE_SLTU, mips_isa_pkg::EXE_SLL, mips_isa_pkg::EXE_SRL,
		mips_isa_pkg::EXE_SRA, mips_isa_pkg::EXE_SLLV, mips_isa_pkg::EXE_SRLV,
		mips_isa_pkg::EXE_SRAV, mips_isa_pkg::EXE_TEQ, mips_isa_pkg::EXE_TNE,
		mips_isa_pkg::EXE_TGE, mips_isa_pkg::EXE_TGEU, mips_isa_pkg::EXE_TLT,
		mips_isa_pkg::EXE_TLTU};
	localparam logic [6*12-1:0] I_OPS = {
		mips_isa_pkg::EXE_ADDI, mips_isa_pkg::EXE_ADDIU, mips_isa_pkg::EXE_SLTI,
		mips_isa_pkg::EXE_SLTIU, mips_isa_pkg::EXE_ANDI, mips_isa_pkg::EXE_ORI,
		mips_isa_pkg::EXE_XORI, mips_isa_pkg::EXE_LUI, mips_isa_pkg::EXE_BEQ,
		mips_isa_pkg::EXE_BNE, mips_isa_pkg::EXE_BGTZ, mips_isa_pkg::EXE_BLEZ};
	localparam logic [5*10-1:0] REGIMM_RTS = {
		mips_isa_pkg::EXE_BLTZ, mips_isa_pkg::EXE_BLTZAL, mips_isa_pkg::EXE_BGEZ,
		mips_isa_pkg::EXE_BGEZAL, mips_isa_pkg::EXE_TEQI, mips_isa_pkg::EXE_TNEI,
		mips_isa_pkg::EXE_TGEI, mips_isa_pkg::EXE_TGEIU, mips_isa_pkg::EXE_TLTI,
		mips_isa_pkg::EXE_TLTIU};

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	logic [mips_isa_pkg::INSTR_W-1:0] instr;
	logic [mips_isa_pkg::INSTR_W-1:0] rs_value;
	logic [mips_isa_pkg::INSTR_W-1:0] rt_value;
	logic out_valid;
	logic out_ready;
	logic [mips_isa_pkg::INSTR_W-1:0] result;
	logic overflow;
	logic trap;
	logic branch_taken;
	logic [34:0] predicted;
	logic strict_timing;
	logic hold_ready;
	logic [31:0] a;
	logic [31:0] b;
	int seed;
	int tb_errors;
	int check_errors;
	int pending;
	int max_in_flight;

	exec_pipe_top dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.in_ready     (in_ready),
		.instr        (instr),
		.rs_value     (rs_value),
		.rt_value     (rt_value),
		.out_valid    (out_valid),
		.out_ready    (out_ready),
		.result       (result),
		.overflow     (overflow),
		.trap         (trap),
		.branch_taken (branch_taken)
	);

	exec_pipe_checker checker_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.strict_timing    (strict_timing),
		.in_valid         (in_valid),
		.in_ready         (in_ready),
		.out_valid        (out_valid),
		.out_ready        (out_ready),
		.result           (result),
		.overflow         (overflow),
		.trap             (trap),
		.branch_taken     (branch_taken),
		.exp_result       (predicted[34:3]),
		.exp_overflow     (predicted[2]),
		.exp_trap         (predicted[1]),
		.exp_branch_taken (predicted[0]),
		.errors           (check_errors),
		.pending          (pending),
		.max_in_flight    (max_in_flight)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] count_leading_bits(input logic [31:0] value,
		input logic lead);
		int n;
		n = 0;
		while (n < 32 && value[31 - n] == lead) begin
			n++;
		end
		return n;
	endfunction

	// reference model packed as {result, overflow, trap, branch_taken}
	function automatic logic [34:0] predict(input logic [31:0] w, input logic [31:0] rs,
		input logic [31:0] rt);
		logic [31:0] sx;
		logic [31:0] zx;
		logic [32:0] wide;
		logic [31:0] r;
		logic ov;
		logic tr;
		logic br;
		sx = {{16{w[15]}}, w[15:0]};
		zx = {16'h0000, w[15:0]};
		r = '0;
		ov = 1'b0;
		tr = 1'b0;
		br = 1'b0;
		case (w[31:26])
			mips_isa_pkg::EXE_R_TYPE: begin
				case (w[5:0])
					mips_isa_pkg::EXE_AND:  r = rs & rt;
					mips_isa_pkg::EXE_OR:   r = rs | rt;
					mips_isa_pkg::EXE_XOR:  r = rs ^ rt;
					mips_isa_pkg::EXE_NOR:  r = ~(rs | rt);
					mips_isa_pkg::EXE_ADD: begin
						wide = {rs[31], rs} + {rt[31], rt};
						r = wide[31:0];
						ov = wide[32] != wide[31];
					end
					mips_isa_pkg::EXE_ADDU: r = rs + rt;
					mips_isa_pkg::EXE_SUB: begin
						wide = {rs[31], rs} - {rt[31], rt};
						r = wide[31:0];
						ov = wide[32] != wide[31];
					end
					mips_isa_pkg::EXE_SUBU: r = rs - rt;
					mips_isa_pkg::EXE_SLT:  r = {31'b0, $signed(rs) < $signed(rt)};
					mips_isa_pkg::EXE_SLTU: r = {31'b0, rs < rt};
					mips_isa_pkg::EXE_SLL:  r = rt << w[10:6];
					mips_isa_pkg::EXE_SRL:  r = rt >> w[10:6];
					mips_isa_pkg::EXE_SRA:  r = $signed(rt) >>> w[10:6];
					mips_isa_pkg::EXE_SLLV: r = rt << rs[4:0];
					mips_isa_pkg::EXE_SRLV: r = rt >> rs[4:0];
					mips_isa_pkg::EXE_SRAV: r = $signed(rt) >>> rs[4:0];
					mips_isa_pkg::EXE_TEQ:  tr = rs == rt;
					mips_isa_pkg::EXE_TNE:  tr = rs != rt;
					mips_isa_pkg::EXE_TGE:  tr = $signed(rs) >= $signed(rt);
					mips_isa_pkg::EXE_TGEU: tr = rs >= rt;
					mips_isa_pkg::EXE_TLT:  tr = $signed(rs) < $signed(rt);
					mips_isa_pkg::EXE_TLTU: tr = rs < rt;
					default: ;
				endcase
			end
			mips_isa_pkg::EXE_ADDI: begin
				wide = {rs[31], rs} + {sx[31], sx};
				r = wide[31:0];
				ov = wide[32] != wide[31];
			end
			mips_isa_pkg::EXE_ADDIU: r = rs + sx;
			mips_isa_pkg::EXE_SLTI:  r = {31'b0, $signed(rs) < $signed(sx)};
			mips_isa_pkg::EXE_SLTIU: r = {31'b0, rs < sx};
			mips_isa_pkg::EXE_ANDI:  r = rs & zx;
			mips_isa_pkg::EXE_ORI:   r = rs | zx;
			mips_isa_pkg::EXE_XORI:  r = rs ^ zx;
			mips_isa_pkg::EXE_LUI:   r = {w[15:0], 16'h0000};
			mips_isa_pkg::EXE_BEQ:   br = rs == rt;
			mips_isa_pkg::EXE_BNE:   br = rs != rt;
			mips_isa_pkg::EXE_BGTZ:  br = $signed(rs) > 0;
			mips_isa_pkg::EXE_BLEZ:  br = $signed(rs) <= 0;
			mips_isa_pkg::EXE_REGIMM: begin
				case (w[20:16])
					mips_isa_pkg::EXE_BLTZ, mips_isa_pkg::EXE_BLTZAL: br = $signed(rs) < 0;
					mips_isa_pkg::EXE_BGEZ, mips_isa_pkg::EXE_BGEZAL: br = $signed(rs) >= 0;
					mips_isa_pkg::EXE_TEQI:  tr = rs == sx;
					mips_isa_pkg::EXE_TNEI:  tr = rs != sx;
					mips_isa_pkg::EXE_TGEI:  tr = $signed(rs) >= $signed(sx);
					mips_isa_pkg::EXE_TGEIU: tr = rs >= sx;
					mips_isa_pkg::EXE_TLTI:  tr = $signed(rs) < $signed(sx);
					mips_isa_pkg::EXE_TLTIU: tr = rs < sx;
					default: ;
				endcase
			end
			mips_isa_pkg::EXE_SPECIAL2: begin
				if (w[5:0] == mips_isa_pkg::EXE_CLO) begin
					r = count_leading_bits(rs, 1'b1);
				end else if (w[5:0] == mips_isa_pkg::EXE_CLZ) begin
					r = count_leading_bits(rs, 1'b0);
				end
			end
			default: ;
		endcase
		return {r, ov, tr, br};
	endfunction

	always_comb begin
		predicted = predict(instr, rs_value, rt_value);
	end

	function automatic logic [31:0] pick_operand();
		case ($urandom % 8)
			0: return 32'h0000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h7fff_ffff;
			3: return 32'h8000_0000;
			4: return 32'h0000_0001;
			default: return $urandom;
		endcase
	endfunction

	function automatic logic [31:0] random_instr();
		logic [31:0] w;
		int kind;
		w = $urandom;
		kind = $urandom % 20;
		if (kind == 0) begin
			// loads and stores in opcodes 0x20 to 0x2f
			w[31:30] = 2'b10;
			w[29:26] = $urandom % 16;
		end else if (kind == 1) begin
			// multiply and divide functs
			w[31:26] = mips_isa_pkg::EXE_R_TYPE;
			w[5:0] = 6'b011000 | ($urandom % 4);
		end else if (kind < 10) begin
			w[31:26] = mips_isa_pkg::EXE_R_TYPE;
			w[5:0] = R_FUNCTS[6 * ($urandom % 22) +: 6];
		end else if (kind < 15) begin
			w[31:26] = I_OPS[6 * ($urandom % 12) +: 6];
		end else if (kind < 18) begin
			w[31:26] = mips_isa_pkg::EXE_REGIMM;
			w[20:16] = REGIMM_RTS[5 * ($urandom % 10) +: 5];
		end else begin
			w[31:26] = mips_isa_pkg::EXE_SPECIAL2;
			w[5:0] = ($urandom % 2) ? mips_isa_pkg::EXE_CLO : mips_isa_pkg::EXE_CLZ;
		end
		// immediate near the sign boundary
		if (kind >= 10 && kind < 18 && ($urandom % 2)) begin
			case ($urandom % 4)
				0: w[15:0] = 16'h0000;
				1: w[15:0] = 16'h7fff;
				2: w[15:0] = 16'h8000;
				default: w[15:0] = 16'hffff;
			endcase
		end
		return w;
	endfunction

	task automatic tick();
		@(posedge clk);
		if (hold_ready) begin
			out_ready <= 1'b1;
		end else begin
			out_ready <= ($urandom % 3) != 0;
		end
	endtask

	task automatic send_instr(input logic [31:0] w, input logic [31:0] rs,
		input logic [31:0] rt);
		int waited;
		in_valid <= 1'b1;
		instr <= w;
		rs_value <= rs;
		rt_value <= rt;
		waited = 0;
		tick();
		while (!in_ready && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (!in_ready) begin
			$display("timeout: instruction %h was never accepted", w);
			tb_errors++;
		end
		in_valid <= 1'b0;
	endtask

	task automatic drain(input int limit);
		int waited;
		waited = 0;
		tick();
		while (pending != 0 && waited < limit) begin
			tick();
			waited++;
		end
		if (pending != 0) begin
			$display("timeout: %0d results still outstanding after %0d cycles", pending, limit);
			tb_errors++;
		end
	endtask

	initial begin
		seed = 57;
		void'($urandom(seed));
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		instr = '0;
		rs_value = '0;
		rt_value = '0;
		out_ready = 1'b0;
		strict_timing = 1'b0;
		hold_ready = 1'b0;
		tb_errors = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (out_valid !== 1'b0) begin
			$display("Error at %0t ns: out_valid expected 0, got %b", $time, out_valid);
			tb_errors++;
		end
		if (in_ready !== 1'b1) begin
			$display("Error at %0t ns: in_ready expected 1, got %b", $time, in_ready);
			tb_errors++;
		end
		tick();
		// random gaps and output stalls
		for (int n = 0; n < 400; n++) begin
			if ($urandom % 4 == 0) begin
				repeat ($urandom % 3 + 1) tick();
			end
			a = pick_operand();
			b = ($urandom % 6 == 0) ? a : pick_operand();
			send_instr(random_instr(), a, b);
		end
		hold_ready = 1'b1;
		drain(WAIT_LIMIT);
		// back to back stream without back-pressure
		strict_timing <= 1'b1;
		for (int n = 0; n < 40; n++) begin
			a = pick_operand();
			b = ($urandom % 6 == 0) ? a : pick_operand();
			send_instr(random_instr(), a, b);
		end
		strict_timing <= 1'b0;
		drain(WAIT_LIMIT);
		@(negedge clk);
		if (pending != 0) begin
			$display("%0d expected results were never produced", pending);
			tb_errors++;
		end
		if (max_in_flight != 2) begin
			$display("Error at %0t ns: max_in_flight expected 2, got %0d", $time, max_in_flight);
			tb_errors++;
		end
		$display("check errors: %0d, testbench errors: %0d", check_errors, tb_errors);
		if (check_errors + tb_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: verification/exec_pipe_checker.sv
`timescale 1ns/1ns

module exec_pipe_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic strict_timing,
	input  logic in_valid,
	input  logic in_ready,
	input  logic out_valid,
	input  logic out_ready,
	input  logic [mips_isa_pkg::INSTR_W-1:0] result,
	input  logic overflow,
	input  logic trap,
	input  logic branch_taken,
	input  logic [mips_isa_pkg::INSTR_W-1:0] exp_result,
	input  logic exp_overflow,
	input  logic exp_trap,
	input  logic exp_branch_taken,
	output int errors,
	output int pending,
	output int max_in_flight
);

	typedef struct packed {
		logic [31:0] result;
		logic overflow;
		logic trap;
		logic branch_taken;
		logic strict;
		logic [31:0] accepted;
	} expect_t;

	expect_t exp_q[$];
	expect_t head;
	expect_t entry;
	int cycle = 0;
	int err_total = 0;
	int most = 0;

	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			err_total++;
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			exp_q.delete();
			cycle = 0;
			pending <= 0;
		end else begin
			cycle = cycle + 1;
			// oldest entry leaves first
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					$display("Error at %0t ns: output transfer with no instruction outstanding",
						$time);
					err_total++;
				end else begin
					head = exp_q.pop_front();
					compare_value("result", head.result, result);
					compare_value("overflow", head.overflow, overflow);
					compare_value("trap", head.trap, trap);
					compare_value("branch_taken", head.branch_taken, branch_taken);
					// no stalls, so two edges from accept to output
					if (head.strict && (cycle - head.accepted != 2)) begin
						$display("Error at %0t ns: latency expected 2, got %0d", $time,
							cycle - head.accepted);
						err_total++;
					end
				end
			end
			if (in_valid && in_ready) begin
				entry.result = exp_result;
				entry.overflow = exp_overflow;
				entry.trap = exp_trap;
				entry.branch_taken = exp_branch_taken;
				entry.strict = strict_timing;
				entry.accepted = cycle;
				exp_q.push_back(entry);
			end
			if (exp_q.size() > most) begin
				most = exp_q.size();
			end
			pending <= exp_q.size();
		end
		errors <= err_total;
		max_in_flight <= most;
	end

endmodule

// File: src/exec_pipe_top.sv
`timescale 1ns/1ns

module exec_pipe_top (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	output logic in_ready,
	input  logic [mips_isa_pkg::INSTR_W-1:0] instr,
	input  logic [mips_isa_pkg::INSTR_W-1:0] rs_value,
	input  logic [mips_isa_pkg::INSTR_W-1:0] rt_value,
	output logic out_valid,
	input  logic out_ready,
	output logic [mips_isa_pkg::INSTR_W-1:0] result,
	output logic overflow,
	output logic trap,
	output logic branch_taken
);

	logic [alu_ctrl_pkg::ALU_CTRL_W-1:0] dec_alu_control;
	logic [alu_ctrl_pkg::BR_CTRL_W-1:0] dec_branch_control;
	logic [mips_isa_pkg::INSTR_W-1:0] dec_op_a;
	logic [mips_isa_pkg::INSTR_W-1:0] dec_op_b;
	alu_ctrl_pkg::decoded_t dec_data;
	alu_ctrl_pkg::decoded_t s1_data;
	logic s1_valid;
	logic s1_ready;
	logic [mips_isa_pkg::INSTR_W-1:0] ex_result;
	logic ex_overflow;
	logic ex_trap;
	logic ex_branch_taken;
	alu_ctrl_pkg::result_t ex_data;
	alu_ctrl_pkg::result_t s2_data;

	decode_stage decode_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.valid          (in_valid),
		.instr          (instr),
		.rs_value       (rs_value),
		.rt_value       (rt_value),
		.alu_control    (dec_alu_control),
		.branch_control (dec_branch_control),
		.op_a           (dec_op_a),
		.op_b           (dec_op_b)
	);

	assign dec_data = '{alu_control: dec_alu_control, branch_control: dec_branch_control,
		op_a: dec_op_a, op_b: dec_op_b, rt_value: rt_value};

	pipe_stage_reg #(.payload_t(alu_ctrl_pkg::decoded_t)) s1_reg (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (dec_data),
		.out_valid (s1_valid),
		.out_ready (s1_ready),
		.out_data  (s1_data)
	);

	alu_execute execute_i (
		.clk            (clk),
		.valid          (s1_valid),
		.alu_control    (s1_data.alu_control),
		.branch_control (s1_data.branch_control),
		.op_a           (s1_data.op_a),
		.op_b           (s1_data.op_b),
		.rt_value       (s1_data.rt_value),
		.result         (ex_result),
		.overflow       (ex_overflow),
		.trap           (ex_trap),
		.branch_taken   (ex_branch_taken)
	);

	assign ex_data = '{result: ex_result, overflow: ex_overflow, trap: ex_trap,
		branch_taken: ex_branch_taken};

	pipe_stage_reg #(.payload_t(alu_ctrl_pkg::result_t)) s2_reg (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (s1_valid),
		.in_ready  (s1_ready),
		.in_data   (ex_data),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (s2_data)
	);

	assign result       = s2_data.result;
	assign overflow     = s2_data.overflow;
	assign trap         = s2_data.trap;
	assign branch_taken = s2_data.branch_taken;

endmodule

// File: src/alu_execute.sv
`timescale 1ns/1ns

module alu_execute (
	input  logic clk,
	input  logic valid,
	input  logic [alu_ctrl_pkg::ALU_CTRL_W-1:0] alu_control,
	input  logic [alu_ctrl_pkg::BR_CTRL_W-1:0] branch_control,
	input  logic [mips_isa_pkg::INSTR_W-1:0] op_a,
	input  logic [mips_isa_pkg::INSTR_W-1:0] op_b,
	input  logic [mips_isa_pkg::INSTR_W-1:0] rt_value,
	output logic [mips_isa_pkg::INSTR_W-1:0] result,
	output logic overflow,
	output logic trap,
	output logic branch_taken
);

	logic [mips_isa_pkg::INSTR_W-1:0] sum;
	logic [mips_isa_pkg::INSTR_W-1:0] diff;
	logic [4:0] shift_amt;
	logic add_ovf;
	logic sub_ovf;
	logic lt_signed;
	logic lt_unsigned;

	// leading run of bits equal to lead_bit, counted from the msb
	function automatic logic [5:0] count_leading(
		input logic [mips_isa_pkg::INSTR_W-1:0] value,
		input logic lead_bit
	);
		logic [5:0] count;
		logic stop;
		count = '0;
		stop = 1'b0;
		for (int i = mips_isa_pkg::INSTR_W - 1; i >= 0; i--) begin
			if (!stop && value[i] == lead_bit) begin
				count = count + 6'd1;
			end else begin
				stop = 1'b1;
			end
		end
		return count;
	endfunction

	assign sum       = op_a + op_b;
	assign diff      = op_a - op_b;
	assign shift_amt = op_a[4:0];

	// signed overflow from the operand and result signs
	assign add_ovf = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);
	assign sub_ovf = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);

	assign lt_signed   = $signed(op_a) < $signed(op_b);
	assign lt_unsigned = op_a < op_b;

	always_comb begin
		result   = '0;
		overflow = 1'b0;
		trap     = 1'b0;
		case (alu_control)
			alu_ctrl_pkg::ALU_AND:  result = op_a & op_b;
			alu_ctrl_pkg::ALU_OR:   result = op_a | op_b;
			alu_ctrl_pkg::ALU_XOR:  result = op_a ^ op_b;
			alu_ctrl_pkg::ALU_NOR:  result = ~(op_a | op_b);
			alu_ctrl_pkg::ALU_ADD: begin
				result   = sum;
				overflow = add_ovf;
			end
			alu_ctrl_pkg::ALU_ADDU: result = sum;
			alu_ctrl_pkg::ALU_SUB: begin
				result   = diff;
				overflow = sub_ovf;
			end
			alu_ctrl_pkg::ALU_SUBU: result = diff;
			alu_ctrl_pkg::ALU_SLT:  result = {31'b0, lt_signed};
			alu_ctrl_pkg::ALU_SLTU: result = {31'b0, lt_unsigned};
			// op_b carries rt, the value being shifted
			alu_ctrl_pkg::ALU_SLL_SA, alu_ctrl_pkg::ALU_SLL:
				result = op_b << shift_amt;
			alu_ctrl_pkg::ALU_SRL_SA, alu_ctrl_pkg::ALU_SRL:
				result = op_b >> shift_amt;
			alu_ctrl_pkg::ALU_SRA_SA, alu_ctrl_pkg::ALU_SRA:
				result = $signed(op_b) >>> shift_amt;
			alu_ctrl_pkg::ALU_LUI:  result = op_b;
			alu_ctrl_pkg::ALU_CLO:  result = {26'b0, count_leading(op_a, 1'b1)};
			alu_ctrl_pkg::ALU_CLZ:  result = {26'b0, count_leading(op_a, 1'b0)};
			// traps leave result at zero
			alu_ctrl_pkg::ALU_TEQ:  trap = (op_a == op_b);
			alu_ctrl_pkg::ALU_TNE:  trap = (op_a != op_b);
			alu_ctrl_pkg::ALU_TGE:  trap = !lt_signed;
			alu_ctrl_pkg::ALU_TGEU: trap = !lt_unsigned;
			alu_ctrl_pkg::ALU_TLT:  trap = lt_signed;
			alu_ctrl_pkg::ALU_TLTU: trap = lt_unsigned;
			default: ;
		endcase
	end

	// branch judge
	always_comb begin
		case (branch_control)
			alu_ctrl_pkg::BR_EQ:  branch_taken = (op_a == rt_value);
			alu_ctrl_pkg::BR_NEQ: branch_taken = (op_a != rt_value);
			alu_ctrl_pkg::BR_GTZ: branch_taken = !op_a[31] && (op_a != '0);
			alu_ctrl_pkg::BR_LEZ: branch_taken = op_a[31] || (op_a == '0);
			alu_ctrl_pkg::BR_LTZ: branch_taken = op_a[31];
			alu_ctrl_pkg::BR_GEZ: branch_taken = !op_a[31];
			default:              branch_taken = 1'b0;
		endcase
	end

	// decoder never pairs a trap code with a branch code
	trap_branch_excl_a: assert property (@(posedge clk)
		valid |-> !(trap && branch_taken))
		else $error("trap and branch_taken both raised");

endmodule

// File: src/pipe_stage_reg.sv
`timescale 1ns/1ns

module pipe_stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	output logic in_ready,
	input  payload_t in_data,
	output logic out_valid,
	input  logic out_ready,
	output payload_t out_data
);

	logic full;
	payload_t data_q;

	// take a new word when empty or when the held one leaves this cycle
	assign in_ready = !full || out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			full <= 1'b0;
		end else if (in_ready) begin
			full <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_ready && in_valid) begin
			data_q <= in_data;
		end
	end

	assign out_valid = full;
	assign out_data  = data_q;

	hold_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("stalled payload changed before transfer");

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
	input  logic clk,
	input  logic rst_n,
	input  logic valid,
	input  logic [mips_isa_pkg::INSTR_W-1:0] instr,
	input  logic [mips_isa_pkg::INSTR_W-1:0] rs_value,
	input  logic [mips_isa_pkg::INSTR_W-1:0] rt_value,
	output logic [alu_ctrl_pkg::ALU_CTRL_W-1:0] alu_control,
	output logic [alu_ctrl_pkg::BR_CTRL_W-1:0] branch_control,
	output logic [mips_isa_pkg::INSTR_W-1:0] op_a,
	output logic [mips_isa_pkg::INSTR_W-1:0] op_b
);

	logic [mips_isa_pkg::OP_W-1:0] op_code;
	logic [mips_isa_pkg::SHAMT_W-1:0] shamt;
	logic [mips_isa_pkg::IMM_W-1:0] imm;
	logic is_shamt_shift;

	assign op_code = instr[31:26];
	assign shamt   = instr[10:6];
	assign imm     = instr[15:0];

	alu_decoder decoder_i (
		.clk            (clk),
		.valid          (valid && rst_n),
		.instr          (instr),
		.alu_control    (alu_control),
		.branch_control (branch_control)
	);

	// sll, srl and sra take their amount from the instruction word
	assign is_shamt_shift = (alu_control == alu_ctrl_pkg::ALU_SLL_SA) ||
		(alu_control == alu_ctrl_pkg::ALU_SRL_SA) ||
		(alu_control == alu_ctrl_pkg::ALU_SRA_SA);

	assign op_a = is_shamt_shift ?
		{{(mips_isa_pkg::INSTR_W - mips_isa_pkg::SHAMT_W){1'b0}}, shamt} : rs_value;

	always_comb begin
		case (op_code)
			mips_isa_pkg::EXE_ADDI, mips_isa_pkg::EXE_ADDIU, mips_isa_pkg::EXE_SLTI,
			mips_isa_pkg::EXE_SLTIU, mips_isa_pkg::EXE_REGIMM:
				op_b = {{(mips_isa_pkg::INSTR_W - mips_isa_pkg::IMM_W){imm[15]}}, imm};
			mips_isa_pkg::EXE_ANDI, mips_isa_pkg::EXE_ORI, mips_isa_pkg::EXE_XORI:
				op_b = {{(mips_isa_pkg::INSTR_W - mips_isa_pkg::IMM_W){1'b0}}, imm};
			mips_isa_pkg::EXE_LUI:
				op_b = {imm, {(mips_isa_pkg::INSTR_W - mips_isa_pkg::IMM_W){1'b0}}};
			// r-type, special2 and branches
			default:
				op_b = rt_value;
		endcase
	end

endmodule

// File: src/alu_decoder.sv
`timescale 1ns/1ns

module alu_decoder (
	input  logic clk,
	input  logic valid,
	input  logic [mips_isa_pkg::INSTR_W-1:0] instr,
	output logic [alu_ctrl_pkg::ALU_CTRL_W-1:0] alu_control,
	output logic [alu_ctrl_pkg::BR_CTRL_W-1:0] branch_control
);

	logic [mips_isa_pkg::OP_W-1:0] op_code;
	logic [mips_isa_pkg::REG_W-1:0] rt;
	logic [mips_isa_pkg::FUNCT_W-1:0] funct;

	assign op_code = instr[31:26];
	assign rt      = instr[20:16];
	assign funct   = instr[5:0];

	// alu control
	always_comb begin
		case (op_code)
			mips_isa_pkg::EXE_R_TYPE: begin
				case (funct)
					mips_isa_pkg::EXE_AND:  alu_control = alu_ctrl_pkg::ALU_AND;
					mips_isa_pkg::EXE_OR:   alu_control = alu_ctrl_pkg::ALU_OR;
					mips_isa_pkg::EXE_XOR:  alu_control = alu_ctrl_pkg::ALU_XOR;
					mips_isa_pkg::EXE_NOR:  alu_control = alu_ctrl_pkg::ALU_NOR;
					mips_isa_pkg::EXE_ADD:  alu_control = alu_ctrl_pkg::ALU_ADD;
					mips_isa_pkg::EXE_ADDU: alu_control = alu_ctrl_pkg::ALU_ADDU;
					mips_isa_pkg::EXE_SUB:  alu_control = alu_ctrl_pkg::ALU_SUB;
					mips_isa_pkg::EXE_SUBU: alu_control = alu_ctrl_pkg::ALU_SUBU;
					mips_isa_pkg::EXE_SLT:  alu_control = alu_ctrl_pkg::ALU_SLT;
					mips_isa_pkg::EXE_SLTU: alu_control = alu_ctrl_pkg::ALU_SLTU;
					// shifts
					mips_isa_pkg::EXE_SLL:  alu_control = alu_ctrl_pkg::ALU_SLL_SA;
					mips_isa_pkg::EXE_SRL:  alu_control = alu_ctrl_pkg::ALU_SRL_SA;
					mips_isa_pkg::EXE_SRA:  alu_control = alu_ctrl_pkg::ALU_SRA_SA;
					mips_isa_pkg::EXE_SLLV: alu_control = alu_ctrl_pkg::ALU_SLL;
					mips_isa_pkg::EXE_SRLV: alu_control = alu_ctrl_pkg::ALU_SRL;
					mips_isa_pkg::EXE_SRAV: alu_control = alu_ctrl_pkg::ALU_SRA;
					// register form traps
					mips_isa_pkg::EXE_TEQ:  alu_control = alu_ctrl_pkg::ALU_TEQ;
					mips_isa_pkg::EXE_TNE:  alu_control = alu_ctrl_pkg::ALU_TNE;
					mips_isa_pkg::EXE_TGE:  alu_control = alu_ctrl_pkg::ALU_TGE;
					mips_isa_pkg::EXE_TGEU: alu_control = alu_ctrl_pkg::ALU_TGEU;
					mips_isa_pkg::EXE_TLT:  alu_control = alu_ctrl_pkg::ALU_TLT;
					mips_isa_pkg::EXE_TLTU: alu_control = alu_ctrl_pkg::ALU_TLTU;
					default:                alu_control = alu_ctrl_pkg::ALU_DONOTHING;
				endcase
			end
			// I type
			mips_isa_pkg::EXE_ADDI:  alu_control = alu_ctrl_pkg::ALU_ADD;
			mips_isa_pkg::EXE_ADDIU: alu_control = alu_ctrl_pkg::ALU_ADDU;
			mips_isa_pkg::EXE_SLTI:  alu_control = alu_ctrl_pkg::ALU_SLT;
			mips_isa_pkg::EXE_SLTIU: alu_control = alu_ctrl_pkg::ALU_SLTU;
			mips_isa_pkg::EXE_ANDI:  alu_control = alu_ctrl_pkg::ALU_AND;
			mips_isa_pkg::EXE_ORI:   alu_control = alu_ctrl_pkg::ALU_OR;
			mips_isa_pkg::EXE_XORI:  alu_control = alu_ctrl_pkg::ALU_XOR;
			mips_isa_pkg::EXE_LUI:   alu_control = alu_ctrl_pkg::ALU_LUI;
			mips_isa_pkg::EXE_SPECIAL2: begin
				case (funct)
					mips_isa_pkg::EXE_CLO: alu_control = alu_ctrl_pkg::ALU_CLO;
					mips_isa_pkg::EXE_CLZ: alu_control = alu_ctrl_pkg::ALU_CLZ;
					default:               alu_control = alu_ctrl_pkg::ALU_DONOTHING;
				endcase
			end
			// immediate traps live in the rt field
			mips_isa_pkg::EXE_REGIMM: begin
				case (rt)
					mips_isa_pkg::EXE_TEQI:  alu_control = alu_ctrl_pkg::ALU_TEQ;
					mips_isa_pkg::EXE_TNEI:  alu_control = alu_ctrl_pkg::ALU_TNE;
					mips_isa_pkg::EXE_TGEI:  alu_control = alu_ctrl_pkg::ALU_TGE;
					mips_isa_pkg::EXE_TGEIU: alu_control = alu_ctrl_pkg::ALU_TGEU;
					mips_isa_pkg::EXE_TLTI:  alu_control = alu_ctrl_pkg::ALU_TLT;
					mips_isa_pkg::EXE_TLTIU: alu_control = alu_ctrl_pkg::ALU_TLTU;
					default:                 alu_control = alu_ctrl_pkg::ALU_DONOTHING;
				endcase
			end
			default: alu_control = alu_ctrl_pkg::ALU_DONOTHING;
		endcase
	end

	// branch judge control
	always_comb begin
		case (op_code)
			mips_isa_pkg::EXE_BEQ:  branch_control = alu_ctrl_pkg::BR_EQ;
			mips_isa_pkg::EXE_BNE:  branch_control = alu_ctrl_pkg::BR_NEQ;
			mips_isa_pkg::EXE_BGTZ: branch_control = alu_ctrl_pkg::BR_GTZ;
			mips_isa_pkg::EXE_BLEZ: branch_control = alu_ctrl_pkg::BR_LEZ;
			mips_isa_pkg::EXE_REGIMM: begin
				case (rt)
					mips_isa_pkg::EXE_BLTZ, mips_isa_pkg::EXE_BLTZAL:
						branch_control = alu_ctrl_pkg::BR_LTZ;
					mips_isa_pkg::EXE_BGEZ, mips_isa_pkg::EXE_BGEZAL:
						branch_control = alu_ctrl_pkg::BR_GEZ;
					default:
						branch_control = alu_ctrl_pkg::BR_NONE;
				endcase
			end
			default: branch_control = alu_ctrl_pkg::BR_NONE;
		endcase
	end

	// a valid upstream word must decode to known controls
	ctrl_known_a: assert property (@(posedge clk)
		valid |-> !$isunknown({alu_control, branch_control}))
		else $error("decoder output unknown for a valid instruction");

endmodule

// File: src/alu_ctrl_pkg.sv
package alu_ctrl_pkg;

	localparam int ALU_CTRL_W = 6;
	localparam int BR_CTRL_W  = 5;

	// ALU control codes
	localparam logic [ALU_CTRL_W-1:0] ALU_DONOTHING = 6'd0;
	localparam logic [ALU_CTRL_W-1:0] ALU_AND       = 6'd1;
	localparam logic [ALU_CTRL_W-1:0] ALU_OR        = 6'd2;
	localparam logic [ALU_CTRL_W-1:0] ALU_XOR       = 6'd3;
	localparam logic [ALU_CTRL_W-1:0] ALU_NOR       = 6'd4;
	localparam logic [ALU_CTRL_W-1:0] ALU_ADD       = 6'd5;
	localparam logic [ALU_CTRL_W-1:0] ALU_ADDU      = 6'd6;
	localparam logic [ALU_CTRL_W-1:0] ALU_SUB       = 6'd7;
	localparam logic [ALU_CTRL_W-1:0] ALU_SUBU      = 6'd8;
	localparam logic [ALU_CTRL_W-1:0] ALU_SLT       = 6'd9;
	localparam logic [ALU_CTRL_W-1:0] ALU_SLTU      = 6'd10;
	// shift by shamt field
	localparam logic [ALU_CTRL_W-1:0] ALU_SLL_SA    = 6'd11;
	localparam logic [ALU_CTRL_W-1:0] ALU_SRL_SA    = 6'd12;
	localparam logic [ALU_CTRL_W-1:0] ALU_SRA_SA    = 6'd13;
	// shift by rs
	localparam logic [ALU_CTRL_W-1:0] ALU_SLL       = 6'd14;
	localparam logic [ALU_CTRL_W-1:0] ALU_SRL       = 6'd15;
	localparam logic [ALU_CTRL_W-1:0] ALU_SRA       = 6'd16;
	localparam logic [ALU_CTRL_W-1:0] ALU_LUI       = 6'd17;
	localparam logic [ALU_CTRL_W-1:0] ALU_CLO       = 6'd18;
	localparam logic [ALU_CTRL_W-1:0] ALU_CLZ       = 6'd19;
	localparam logic [ALU_CTRL_W-1:0] ALU_TEQ       = 6'd20;
	localparam logic [ALU_CTRL_W-1:0] ALU_TNE       = 6'd21;
	localparam logic [ALU_CTRL_W-1:0] ALU_TGE       = 6'd22;
	localparam logic [ALU_CTRL_W-1:0] ALU_TGEU      = 6'd23;
	localparam logic [ALU_CTRL_W-1:0] ALU_TLT       = 6'd24;
	localparam logic [ALU_CTRL_W-1:0] ALU_TLTU      = 6'd25;

	// branch judge codes
	localparam logic [BR_CTRL_W-1:0] BR_NONE = 5'd0;
	localparam logic [BR_CTRL_W-1:0] BR_EQ   = 5'd1;
	localparam logic [BR_CTRL_W-1:0] BR_NEQ  = 5'd2;
	localparam logic [BR_CTRL_W-1:0] BR_GTZ  = 5'd3;
	localparam logic [BR_CTRL_W-1:0] BR_LEZ  = 5'd4;
	localparam logic [BR_CTRL_W-1:0] BR_LTZ  = 5'd5;
	localparam logic [BR_CTRL_W-1:0] BR_GEZ  = 5'd6;

	// payload between decode and execute
	typedef struct packed {
		logic [ALU_CTRL_W-1:0] alu_control;
		logic [BR_CTRL_W-1:0] branch_control;
		logic [mips_isa_pkg::INSTR_W-1:0] op_a;
		logic [mips_isa_pkg::INSTR_W-1:0] op_b;
		logic [mips_isa_pkg::INSTR_W-1:0] rt_value;
	} decoded_t;

	// payload after execute
	typedef struct packed {
		logic [mips_isa_pkg::INSTR_W-1:0] result;
		logic overflow;
		logic trap;
		logic branch_taken;
	} result_t;

endpackage

// File: src/mips_isa_pkg.sv
package mips_isa_pkg;

	// data path and instruction width
	localparam int INSTR_W = 32;

	// field widths
	localparam int OP_W    = 6;
	localparam int FUNCT_W = 6;
	localparam int REG_W   = 5;
	localparam int SHAMT_W = 5;
	localparam int IMM_W   = 16;

	// primary opcodes
	localparam logic [OP_W-1:0] EXE_R_TYPE   = 6'b000000;
	localparam logic [OP_W-1:0] EXE_REGIMM   = 6'b000001;
	localparam logic [OP_W-1:0] EXE_BEQ      = 6'b000100;
	localparam logic [OP_W-1:0] EXE_BNE      = 6'b000101;
	localparam logic [OP_W-1:0] EXE_BLEZ     = 6'b000110;
	localparam logic [OP_W-1:0] EXE_BGTZ     = 6'b000111;
	localparam logic [OP_W-1:0] EXE_ADDI     = 6'b001000;
	localparam logic [OP_W-1:0] EXE_ADDIU    = 6'b001001;
	localparam logic [OP_W-1:0] EXE_SLTI     = 6'b001010;
	localparam logic [OP_W-1:0] EXE_SLTIU    = 6'b001011;
	localparam logic [OP_W-1:0] EXE_ANDI     = 6'b001100;
	localparam logic [OP_W-1:0] EXE_ORI      = 6'b001101;
	localparam logic [OP_W-1:0] EXE_XORI     = 6'b001110;
	localparam logic [OP_W-1:0] EXE_LUI      = 6'b001111;
	localparam logic [OP_W-1:0] EXE_SPECIAL2 = 6'b011100;

	// R-type funct, shifts and arithmetic
	localparam logic [FUNCT_W-1:0] EXE_SLL  = 6'b000000;
	localparam logic [FUNCT_W-1:0] EXE_SRL  = 6'b000010;
	localparam logic [FUNCT_W-1:0] EXE_SRA  = 6'b000011;
	localparam logic [FUNCT_W-1:0] EXE_SLLV = 6'b000100;
	localparam logic [FUNCT_W-1:0] EXE_SRLV = 6'b000110;
	localparam logic [FUNCT_W-1:0] EXE_SRAV = 6'b000111;
	localparam logic [FUNCT_W-1:0] EXE_ADD  = 6'b100000;
	localparam logic [FUNCT_W-1:0] EXE_ADDU = 6'b100001;
	localparam logic [FUNCT_W-1:0] EXE_SUB  = 6'b100010;
	localparam logic [FUNCT_W-1:0] EXE_SUBU = 6'b100011;
	localparam logic [FUNCT_W-1:0] EXE_AND  = 6'b100100;
	localparam logic [FUNCT_W-1:0] EXE_OR   = 6'b100101;
	localparam logic [FUNCT_W-1:0] EXE_XOR  = 6'b100110;
	localparam logic [FUNCT_W-1:0] EXE_NOR  = 6'b100111;
	localparam logic [FUNCT_W-1:0] EXE_SLT  = 6'b101010;
	localparam logic [FUNCT_W-1:0] EXE_SLTU = 6'b101011;

	// R-type register traps
	localparam logic [FUNCT_W-1:0] EXE_TGE  = 6'b110000;
	localparam logic [FUNCT_W-1:0] EXE_TGEU = 6'b110001;
	localparam logic [FUNCT_W-1:0] EXE_TLT  = 6'b110010;
	localparam logic [FUNCT_W-1:0] EXE_TLTU = 6'b110011;
	localparam logic [FUNCT_W-1:0] EXE_TEQ  = 6'b110100;
	localparam logic [FUNCT_W-1:0] EXE_TNE  = 6'b110110;

	// SPECIAL2 funct
	localparam logic [FUNCT_W-1:0] EXE_CLZ = 6'b100000;
	localparam logic [FUNCT_W-1:0] EXE_CLO = 6'b100001;

	// REGIMM rt field, branches and immediate traps
	localparam logic [REG_W-1:0] EXE_BLTZ   = 5'b00000;
	localparam logic [REG_W-1:0] EXE_BGEZ   = 5'b00001;
	localparam logic [REG_W-1:0] EXE_TGEI   = 5'b01000;
	localparam logic [REG_W-1:0] EXE_TGEIU  = 5'b01001;
	localparam logic [REG_W-1:0] EXE_TLTI   = 5'b01010;
	localparam logic [REG_W-1:0] EXE_TLTIU  = 5'b01011;
	localparam logic [REG_W-1:0] EXE_TEQI   = 5'b01100;
	localparam logic [REG_W-1:0] EXE_TNEI   = 5'b01110;
	localparam logic [REG_W-1:0] EXE_BLTZAL = 5'b10000;
	localparam logic [REG_W-1:0] EXE_BGEZAL = 5'b10001;

endpackage
